// ==== design/stk_pkg.sv ====
package stk_pkg;

    localparam int MASK_W       = 8;    // Post-byte width
    localparam int ADDR_W       = 16;   // Stack address width
    localparam int RAM_AW       = 10;   // Decoded RAM address bits, wraps above
    localparam int WORD16_FIRST = 4;    // Mask bits from here up are 16-bit registers

    // Bit 0 picks the U stack, bit 1 marks a pull
    typedef enum logic [7:0] {
        PSHS = 8'h34,
        PSHU = 8'h35,
        PULS = 8'h36,
        PULU = 8'h37
    } stk_op_e;

    // Register index on the load/read port
    typedef enum logic [3:0] {
        CC = 4'd0,
        A  = 4'd1,
        B  = 4'd2,
        DP = 4'd3,
        X  = 4'd4,
        Y  = 4'd5,
        U  = 4'd6,
        S  = 4'd7,
        PC = 4'd8
    } stk_reg_e;

endpackage

// ==== design/stk_cmd.sv ====
`timescale 1ns/100ps

module stk_cmd (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  stk_pkg::stk_op_e            cmd_op,
    input  logic [stk_pkg::MASK_W-1:0]  cmd_postbyte,
    input  logic                        idle,
    output logic                        cmd_ready,
    output logic                        cmd_err,
    output logic                        psh_go,
    output logic                        pul_go,
    output logic [7:0]                  op,
    output logic [stk_pkg::MASK_W-1:0]  postbyte
);
    import stk_pkg::*;

    logic start_pend;   // Command taken, go not yet issued
    logic legal;

    assign cmd_ready = idle && !start_pend;   // Drops right after the accept edge
    assign legal     = (op == PSHS) || (op == PSHU) || (op == PULS) || (op == PULU);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_pend <= 1'b0;
        end else begin
            start_pend <= cmd_valid && cmd_ready;
        end
    end

    // Command payload, held until the next acceptance
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op       <= cmd_op;
            postbyte <= cmd_postbyte;
        end
    end

    assign psh_go  = start_pend && legal && !op[1];   // Bit 1 low means push
    assign pul_go  = start_pend && legal && op[1];
    assign cmd_err = start_pend && !legal;            // Same slot the go would use

    a_go_excl: assert property (@(posedge clk) disable iff (rst) !(psh_go && pul_go));

endmodule

// ==== design/stk_seq.sv ====
`timescale 1ns/100ps

module stk_seq (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  op,
    input  logic [stk_pkg::MASK_W-1:0]  postbyte,
    input  logic                        psh_go,
    input  logic                        pul_go,
    input  logic [stk_pkg::MASK_W-1:0]  psh_bit,
    input  logic                        step,
    output logic                        hi_lon,
    output logic                        pul_en,
    output logic                        dec_us,
    output logic [stk_pkg::MASK_W-1:0]  psh_sel,
    output logic                        idle,
    output logic                        us_sel
);
    import stk_pkg::*;

    logic wide_pick;    // Current register is 16 bits

    assign idle      = (psh_sel == '0);
    assign wide_pick = (psh_bit[MASK_W-1:WORD16_FIRST] != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psh_sel <= '0;
            hi_lon  <= 1'b0;
            us_sel  <= 1'b0;
            pul_en  <= 1'b0;
            dec_us  <= 1'b0;
        end else if (idle) begin
            if (psh_go || pul_go) begin
                psh_sel <= postbyte;            // Empty mask stays idle
                us_sel  <= op[0];
                hi_lon  <= 1'b1;
                pul_en  <= (postbyte != '0);    // Nothing to move on an empty mask
                dec_us  <= psh_go;
            end
        end else if (step) begin
            if (wide_pick && hi_lon) begin
                hi_lon <= 1'b0;             // First half done, same register again
            end else begin
                hi_lon  <= 1'b1;
                psh_sel <= psh_sel & ~psh_bit;
                pul_en  <= ((psh_sel & ~psh_bit) != '0);   // Falls with the last byte
            end
        end
    end

    // The register file pick must be a single live mask bit
    a_pick_onehot: assert property (@(posedge clk) disable iff (rst)
        (psh_sel != '0) |-> $onehot(psh_bit));
    a_pick_subset: assert property (@(posedge clk) disable iff (rst)
        (psh_bit & ~psh_sel) == '0);

endmodule

// ==== design/stk_regs.sv ====
`timescale 1ns/100ps

module stk_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        reg_we,
    input  stk_pkg::stk_reg_e           reg_idx,
    input  logic [15:0]                 reg_wdata,
    input  logic [stk_pkg::MASK_W-1:0]  psh_sel,
    input  logic                        hi_lon,
    input  logic                        dec_us,
    input  logic                        us_sel,
    input  logic                        pul_en,
    input  logic                        idle,
    input  logic                        step,
    input  logic [7:0]                  rd_byte,
    output logic [15:0]                 reg_rdata,
    output logic [stk_pkg::MASK_W-1:0]  psh_bit,
    output logic                        req,
    output logic                        we,
    output logic [stk_pkg::ADDR_W-1:0]  byte_addr,
    output logic [7:0]                  wr_byte
);
    import stk_pkg::*;

    logic [7:0]        cc, a, b, dp;
    logic [15:0]       x, y, u, s, pc;
    logic [2:0]        pick_idx;    // Mask bit number of psh_bit
    logic [15:0]       pick_val;    // Register named by the pick
    logic [ADDR_W-1:0] act_sp;      // Pointer of the stack in use
    logic              wide;
    logic              wr_ok;

    function automatic logic [15:0] merge16(input logic [15:0] old, input logic [7:0] nb,
                                            input logic hi);
        merge16 = hi ? {nb, old[7:0]} : {old[15:8], nb};
    endfunction

    // Push takes the highest bit (PC first), pull the lowest (CC first)
    always_comb begin
        psh_bit = '0;
        if (dec_us) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (psh_sel[i]) psh_bit = MASK_W'(1) << i;
            end
        end else begin
            psh_bit = psh_sel & (~psh_sel + MASK_W'(1));
        end
    end

    always_comb begin
        pick_idx = '0;
        for (int i = 0; i < MASK_W; i++) begin
            if (psh_bit[i]) pick_idx = 3'(i);
        end
    end

    always_comb begin
        case (pick_idx)
            3'd0:    pick_val = {8'h00, cc};
            3'd1:    pick_val = {8'h00, a};
            3'd2:    pick_val = {8'h00, b};
            3'd3:    pick_val = {8'h00, dp};
            3'd4:    pick_val = x;
            3'd5:    pick_val = y;
            3'd6:    pick_val = us_sel ? s : u;   // The other stack pointer
            default: pick_val = pc;
        endcase
    end

    assign wide      = (pick_idx >= WORD16_FIRST);
    assign act_sp    = us_sel ? u : s;
    assign wr_byte   = (!wide || hi_lon) ? pick_val[7:0] : pick_val[15:8]; // Low byte first
    assign byte_addr = dec_us ? act_sp - 1'b1 : act_sp;   // Pre-decrement on push
    assign we        = dec_us;
    assign req       = pul_en && !idle;
    assign wr_ok     = reg_we && idle && !pul_en;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            case (reg_idx)
                CC:      cc <= reg_wdata[7:0];
                A:       a  <= reg_wdata[7:0];
                B:       b  <= reg_wdata[7:0];
                DP:      dp <= reg_wdata[7:0];
                X:       x  <= reg_wdata;
                Y:       y  <= reg_wdata;
                U:       u  <= reg_wdata;
                S:       s  <= reg_wdata;
                PC:      pc <= reg_wdata;
                default: ;
            endcase
        end else if (step) begin
            if (us_sel) u <= dec_us ? u - 16'd1 : u + 16'd1;
            else        s <= dec_us ? s - 16'd1 : s + 16'd1;
            if (!dec_us) begin
                case (pick_idx)                    // Pull lands high byte first
                    3'd0: cc <= rd_byte;
                    3'd1: a  <= rd_byte;
                    3'd2: b  <= rd_byte;
                    3'd3: dp <= rd_byte;
                    3'd4: x  <= merge16(x, rd_byte, hi_lon);
                    3'd5: y  <= merge16(y, rd_byte, hi_lon);
                    3'd6: begin
                        if (us_sel) s <= merge16(s, rd_byte, hi_lon);
                        else        u <= merge16(u, rd_byte, hi_lon);
                    end
                    default: pc <= merge16(pc, rd_byte, hi_lon);
                endcase
            end
        end
    end

    always_comb begin
        case (reg_idx)
            CC:      reg_rdata = {8'h00, cc};
            A:       reg_rdata = {8'h00, a};
            B:       reg_rdata = {8'h00, b};
            DP:      reg_rdata = {8'h00, dp};
            X:       reg_rdata = x;
            Y:       reg_rdata = y;
            U:       reg_rdata = u;
            S:       reg_rdata = s;
            PC:      reg_rdata = pc;
            default: reg_rdata = 16'h0000;
        endcase
    end

    a_no_we_busy: assert property (@(posedge clk) disable iff (rst) reg_we |-> !pul_en);

endmodule

// ==== design/stk_wb_master.sv ====
`timescale 1ns/100ps

module stk_wb_master (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  logic                        we,
    input  logic [stk_pkg::ADDR_W-1:0]  byte_addr,
    input  logic [7:0]                  wr_byte,
    output logic                        step,
    output logic [7:0]                  rd_byte,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [stk_pkg::ADDR_W-1:0]  wb_adr,
    output logic [7:0]                  wb_dat_w,
    input  logic [7:0]                  wb_dat_r,
    input  logic                        wb_ack
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        GAP
    } state_e;

    state_e state;

    assign wb_cyc = (state == BUS);   // cyc and stb move together
    assign wb_stb = (state == BUS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            step  <= 1'b0;
        end else begin
            step <= 1'b0;
            case (state)
                IDLE: if (req) state <= BUS;
                BUS: begin
                    if (wb_ack) begin
                        state <= GAP;
                        step  <= 1'b1;        // Sequencer and pointer advance in GAP
                    end
                end
                GAP:     state <= IDLE;       // req is stale until step lands
                default: state <= IDLE;
            endcase
        end
    end

    // Bus payload latched at cycle start, read data on ack
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            wb_adr   <= byte_addr;
            wb_dat_w <= wr_byte;
            wb_we    <= we;
        end
        if (state == BUS && wb_ack) begin
            rd_byte <= wb_dat_r;
        end
    end

    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(wb_stb) |-> $past(wb_ack));

endmodule

// ==== design/stk_ram.sv ====
`timescale 1ns/100ps

module stk_ram (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [stk_pkg::ADDR_W-1:0]  wb_adr,
    input  logic [7:0]                  wb_dat_w,
    output logic [7:0]                  wb_dat_r,
    output logic                        wb_ack
);
    import stk_pkg::*;

    logic [7:0]        mem [0:(1 << RAM_AW) - 1];
    logic [RAM_AW-1:0] ram_a;   // Upper address bits ignored
    logic              hit;

    assign ram_a = wb_adr[RAM_AW-1:0];
    assign hit   = wb_cyc && wb_stb && !wb_ack;   // No second ack back to back

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (wb_we) mem[ram_a] <= wb_dat_w;
            wb_dat_r <= mem[ram_a];   // Valid alongside ack
        end
    end

endmodule

// ==== design/stk_top.sv ====
`timescale 1ns/100ps

module stk_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  stk_pkg::stk_op_e            cmd_op,
    input  logic [stk_pkg::MASK_W-1:0]  cmd_postbyte,
    output logic                        cmd_ready,
    output logic                        cmd_err,
    input  logic                        reg_we,
    input  stk_pkg::stk_reg_e           reg_idx,
    input  logic [15:0]                 reg_wdata,
    output logic [15:0]                 reg_rdata,
    output logic                        busy
);

    logic [7:0]                  op;
    logic [stk_pkg::MASK_W-1:0]  postbyte;
    logic                        psh_go, pul_go;
    logic [stk_pkg::MASK_W-1:0]  psh_sel, psh_bit;
    logic                        hi_lon, pul_en, dec_us, us_sel, idle;
    logic                        req, we, step;
    logic [stk_pkg::ADDR_W-1:0]  byte_addr, wb_adr;
    logic [7:0]                  wr_byte, rd_byte;
    logic                        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [7:0]                  wb_dat_w, wb_dat_r;

    assign busy = !cmd_ready;

    stk_cmd stk_cmd_inst (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_postbyte, .idle,
        .cmd_ready, .cmd_err, .psh_go, .pul_go, .op, .postbyte
    );

    stk_seq stk_seq_inst (
        .clk, .rst, .op, .postbyte, .psh_go, .pul_go, .psh_bit, .step,
        .hi_lon, .pul_en, .dec_us, .psh_sel, .idle, .us_sel
    );

    stk_regs stk_regs_inst (
        .clk, .rst, .reg_we, .reg_idx, .reg_wdata, .psh_sel, .hi_lon, .dec_us,
        .us_sel, .pul_en, .idle, .step, .rd_byte,
        .reg_rdata, .psh_bit, .req, .we, .byte_addr, .wr_byte
    );

    stk_wb_master stk_wb_master_inst (
        .clk, .rst, .req, .we, .byte_addr, .wr_byte, .step, .rd_byte,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    stk_ram stk_ram_inst (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

endmodule

// ==== sim/stk_checker.sv ====
`timescale 1ns/100ps

module stk_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  logic              cmd_ready,
    input  logic              cmd_err,
    input  logic              busy,
    input  stk_pkg::stk_reg_e reg_idx,
    input  logic [15:0]       reg_rdata,
    input  logic              chk_reg,    // Compare reg_rdata in this cycle
    input  logic [15:0]       exp_val,
    input  logic              chk_err     // One more cmd_err due by now
);

    int checks     = 0;
    int mismatches = 0;
    int err_seen   = 0;     // cmd_err pulses seen on the port
    int err_exp    = 0;     // ERR records so far
    bit fresh      = 1'b1;  // First sample after reset release still due
    bit taking     = 1'b0;  // Handshake seen, command taken on the coming edge

    // Mid-cycle sampling, clear of the edge the testbench drives on
    always @(negedge clk) begin
        if (rst) begin
            fresh  = 1'b1;
            taking = 1'b0;
        end else begin
            if (fresh) begin
                checks++;
                if (cmd_ready !== 1'b1) begin
                    $display("MISMATCH t=%0t signal=cmd_ready expected=%b actual=%b",
                             $time, 1'b1, cmd_ready);
                    mismatches++;
                end
                if (busy !== 1'b0) begin
                    $display("MISMATCH t=%0t signal=busy expected=%b actual=%b",
                             $time, 1'b0, busy);
                    mismatches++;
                end
                fresh = 1'b0;
            end
            if (cmd_err === 1'b1) begin
                err_seen++;                           // Pulse is one cycle wide
            end
            if (taking) begin
                checks++;                             // Busy from acceptance on
                if (busy !== 1'b1) begin
                    $display("MISMATCH t=%0t signal=busy expected=%b actual=%b",
                             $time, 1'b1, busy);
                    mismatches++;
                end
            end
            taking = cmd_valid && cmd_ready;
            if (chk_reg) begin
                checks++;
                if (reg_rdata !== exp_val) begin
                    $display("MISMATCH t=%0t signal=reg_rdata(%s) expected=%h actual=%h",
                             $time, reg_idx.name(), exp_val, reg_rdata);
                    mismatches++;
                end
            end
            if (chk_err) begin
                checks++;
                err_exp++;
                if (err_seen != err_exp) begin
                    $display("MISMATCH t=%0t signal=cmd_err_count expected=%0d actual=%0d",
                             $time, err_exp, err_seen);
                    mismatches++;
                end
            end
        end
    end

    // End of run, catches a stray cmd_err after the last ERR record
    task automatic report(input int other_errors, output int total);
        if (err_seen != err_exp) begin
            $display("MISMATCH t=%0t signal=cmd_err_count expected=%0d actual=%0d",
                     $time, err_exp, err_seen);
            mismatches++;
        end
        total = mismatches + other_errors;
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, other_errors);
    endtask

endmodule

// ==== sim/tb_stk.sv ====
`timescale 1ns/100ps

module tb_stk;
    import stk_pkg::*;

    logic              clk, rst;
    logic              cmd_valid, cmd_ready, cmd_err, busy;
    stk_op_e           cmd_op;
    logic [MASK_W-1:0] cmd_postbyte;
    logic              reg_we;
    stk_reg_e          reg_idx;
    logic [15:0]       reg_wdata, reg_rdata;
    logic              chk_reg, chk_err;
    logic [15:0]       exp_val;
    int                tb_errors = 0;            // Timeouts and stimulus file problems
    int                rec_no = 0;
    bit                hung = 1'b0;
    string             last_cmd = "reset release";

    stk_top stk_top_inst (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_postbyte, .cmd_ready, .cmd_err,
        .reg_we, .reg_idx, .reg_wdata, .reg_rdata, .busy
    );

    stk_checker stk_checker_inst (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd_err, .busy, .reg_idx, .reg_rdata,
        .chk_reg, .exp_val, .chk_err
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Held until the engine takes commands and register writes again
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        forever begin
            if (cmd_ready) break;
            if (cycles == 200) begin
                $display("ERROR: %s hung, cmd_ready not back within 200 cycles (record %0d)",
                         last_cmd, rec_no);
                tb_errors++;
                hung = 1'b1;
                break;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic issue_cmd(input logic [7:0] op, input logic [7:0] mask);
        int   cycles;
        logic taken;
        cycles = 0;
        taken = 1'b0;
        last_cmd = $sformatf("CMD op %h mask %h", op, mask);
        cmd_op = stk_op_e'(op);                  // Illegal codes go through as they are
        cmd_postbyte = mask;
        cmd_valid = 1'b1;
        while (!taken && !hung) begin
            taken = cmd_ready;                   // Ready before the edge means accepted on it
            @(posedge clk);
            #1;
            cycles++;
            if (!taken && cycles == 200) begin
                $display("ERROR: %s not accepted within 200 cycles", last_cmd);
                tb_errors++;
                hung = 1'b1;
            end
        end
        cmd_valid = 1'b0;
    endtask

    task automatic pulse_check(input logic is_reg, input stk_reg_e idx, input logic [15:0] val);
        reg_idx = idx;
        exp_val = val;
        chk_reg = is_reg;
        chk_err = !is_reg;
        @(posedge clk);
        #1;
        chk_reg = 1'b0;
        chk_err = 1'b0;
    endtask

    function automatic int reg_code(input string nm);
        case (nm)
            "CC":    reg_code = int'(CC);
            "A":     reg_code = int'(A);
            "B":     reg_code = int'(B);
            "DP":    reg_code = int'(DP);
            "X":     reg_code = int'(X);
            "Y":     reg_code = int'(Y);
            "U":     reg_code = int'(U);
            "S":     reg_code = int'(S);
            "PC":    reg_code = int'(PC);
            default: reg_code = -1;
        endcase
    endfunction

    initial begin
        int          fd;
        int          n;
        int          code;
        int          total;
        string       kind;
        string       name;
        string       rest;
        logic [15:0] val;
        logic [7:0]  op;
        logic [7:0]  mask;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = PSHS;
        cmd_postbyte = '0;
        reg_we = 1'b0;
        reg_idx = CC;
        reg_wdata = '0;
        chk_reg = 1'b0;
        chk_err = 1'b0;
        exp_val = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = $fopen("sim/stk_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open sim/stk_stim.txt");
            tb_errors++;
        end else begin
            while (!hung && $fscanf(fd, "%s", kind) == 1) begin
                if (kind.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);        // Comment, skip to end of line
                end else begin
                    rec_no++;
                    wait_ready();                // Every record is held until the engine is free
                    if (hung) begin
                        break;
                    end
                    if (kind == "LOAD" || kind == "EXPECT") begin
                        n = $fscanf(fd, "%s %h", name, val);
                        code = reg_code(name);
                        if (n != 2 || code < 0) begin
                            $display("ERROR: bad register field in record %0d", rec_no);
                            tb_errors++;
                        end else if (kind == "LOAD") begin
                            reg_idx = stk_reg_e'(code);
                            reg_wdata = val;
                            reg_we = 1'b1;
                            @(posedge clk);
                            #1;
                            reg_we = 1'b0;
                        end else begin
                            pulse_check(1'b1, stk_reg_e'(code), val);
                        end
                    end else if (kind == "CMD") begin
                        n = $fscanf(fd, "%h %h", op, mask);
                        if (n != 2) begin
                            $display("ERROR: bad command field in record %0d", rec_no);
                            tb_errors++;
                        end else begin
                            issue_cmd(op, mask);
                        end
                    end else if (kind == "ERR") begin
                        pulse_check(1'b0, CC, '0);
                    end else begin
                        $display("ERROR: unknown record kind %s in record %0d", kind, rec_no);
                        tb_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        stk_checker_inst.report(tb_errors, total);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/stk_stim.txt ====
# Records: LOAD <reg> <hex16> | CMD <opcode hex> <mask hex> | EXPECT <reg> <hex16> | ERR
# ERR means one more cmd_err pulse is due since the start of the run
# Full push and pull on S, 12 bytes
LOAD CC 00A5  LOAD A 0011  LOAD B 0022  LOAD DP 0033  LOAD X 1234
LOAD Y 5678  LOAD U 0300  LOAD S 0200  LOAD PC 9ABC
CMD 34 FF  EXPECT S 01F4  EXPECT U 0300
LOAD CC 0000  LOAD A 0000  LOAD B 0000  LOAD DP 0000  LOAD X 0000
LOAD Y 0000  LOAD U 0000  LOAD PC 0000
CMD 36 FF
EXPECT CC 00A5  EXPECT A 0011  EXPECT B 0022  EXPECT DP 0033  EXPECT X 1234
EXPECT Y 5678  EXPECT U 0300  EXPECT S 0200  EXPECT PC 9ABC
# U stack with PC, S, A, CC, 6 bytes
CMD 35 C3  EXPECT U 02FA  EXPECT S 0200
LOAD S 0000  LOAD PC 0000  LOAD A 00FF  LOAD CC 00FF
CMD 37 C3
EXPECT U 0300  EXPECT S 0200  EXPECT PC 9ABC  EXPECT A 0011  EXPECT CC 00A5
# Push X and A, pull A then X
LOAD X BEEF  LOAD A 0077  CMD 34 12  EXPECT S 01FD
LOAD X 0000  LOAD A 0000
CMD 36 02  EXPECT A 0077  EXPECT X 0000  EXPECT S 01FE
CMD 36 10  EXPECT X BEEF  EXPECT S 0200
# Empty mask on both stacks
CMD 34 00  CMD 37 00
EXPECT S 0200  EXPECT U 0300  EXPECT X BEEF  EXPECT A 0077
# Illegal opcode
CMD 12 FF  ERR
EXPECT S 0200  EXPECT CC 00A5  EXPECT PC 9ABC
# Load right behind a push lands after the push
CMD 34 80  LOAD PC 1111  EXPECT PC 1111  EXPECT S 01FE
CMD 36 80  EXPECT PC 9ABC  EXPECT S 0200

// ==== sim.f ====
design/stk_pkg.sv
design/stk_cmd.sv
design/stk_seq.sv
design/stk_regs.sv
design/stk_wb_master.sv
design/stk_ram.sv
design/stk_top.sv
sim/stk_checker.sv
sim/tb_stk.sv
